/* soc_bus.f */
src/soc_bus_pkg.sv
src/mem_if.sv
src/bus_xbar.sv
src/bram.sv
src/clint.sv
src/uart_tx.sv
src/soc_bus.sv
tb/soc_bus_tb.sv

/* Makefile */
TOP       ?= soc_bus_tb
FILELIST  ?= soc_bus.f
VERILATOR ?= verilator
VFLAGS    ?= --assert --timescale 1ns/1ps
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)_sim
	@out="$$(./$(OBJ_DIR)/$(TOP)_sim)"; echo "$$out"; \
		echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* tb/soc_bus_tb.sv */
module soc_bus_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import soc_bus_pkg::*;

  localparam int BRAM_WORDS   = 256;
  localparam int RTC_DIV      = 4;
  localparam int CLKS_PER_BIT = 8;
  localparam int TIMEOUT      = 2000; // cycles allowed per wait loop

  logic              clk = 1'b0;
  logic              rst;
  logic              imem_valid_i;
  logic              imem_instr_i;
  logic [ADDR_W-1:0] imem_addr_i;
  logic [DATA_W-1:0] imem_wdata_i;
  logic [STRB_W-1:0] imem_wstrb_i;
  logic [DATA_W-1:0] imem_rdata_o;
  logic              imem_ready_o;
  logic              dmem_valid_i;
  logic              dmem_instr_i;
  logic [ADDR_W-1:0] dmem_addr_i;
  logic [DATA_W-1:0] dmem_wdata_i;
  logic [STRB_W-1:0] dmem_wstrb_i;
  logic [DATA_W-1:0] dmem_rdata_o;
  logic              dmem_ready_o;
  logic              tx_o;
  logic              msip_o;
  logic              mtip_o;

  int          cyc = 0;
  int          mismatches = 0;
  int          failures = 0;
  logic [31:0] ram_model [8]; // expected bram words 0..7

  soc_bus #(
    .BRAM_WORDS   (BRAM_WORDS),
    .RTC_DIV      (RTC_DIV),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_soc_bus (.*);

  always #50 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  task automatic report_failure(input string msg);
    failures++;
    $display("%s", msg);
  endtask

  task automatic abort_run(input string why);
    failures++;
    $display("%s", why);
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // byte lanes selected by strb come from new_w
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic verify_idle();
    compare("imem_ready_o", 32'h0, 32'(imem_ready_o));
    compare("dmem_ready_o", 32'h0, 32'(dmem_ready_o));
    compare("tx_o", 32'h1, 32'(tx_o));
    compare("msip_o", 32'h0, 32'(msip_o));
    compare("mtip_o", 32'h0, 32'(mtip_o));
  endtask

  // one request on either master port, held until ready
  task automatic bus_xfer(input bit dport, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, output logic [31:0] rdata,
                          output int lat, output int rcyc);
    int start;
    bit rdy;
    rdy = 1'b0;
    @(posedge clk);
    #1;
    start = cyc;
    if (dport) begin
      dmem_valid_i = 1'b1;
      dmem_instr_i = 1'b0;
      dmem_addr_i  = addr;
      dmem_wdata_i = wdata;
      dmem_wstrb_i = wstrb;
    end else begin
      imem_valid_i = 1'b1;
      imem_instr_i = 1'b1; // fetch port
      imem_addr_i  = addr;
      imem_wdata_i = wdata;
      imem_wstrb_i = wstrb;
    end
    while (!rdy && cyc - start < TIMEOUT) begin
      @(negedge clk);
      rdy = dport ? dmem_ready_o : imem_ready_o;
    end
    if (!rdy) begin
      abort_run($sformatf("no ready on the %s port for address %h",
                          dport ? "dmem" : "imem", addr));
    end else begin
      rdata = dport ? dmem_rdata_o : imem_rdata_o;
      lat   = cyc - start;
      rcyc  = cyc;
      @(posedge clk);
      #1;
      if (dport) dmem_valid_i = 1'b0;
      else imem_valid_i = 1'b0;
    end
  endtask

  // samples tx_o mid-bit, bit 0 is the start bit
  task automatic decode_frame(output logic [9:0] bits, output int stop_cyc);
    int n;
    n = 0;
    bits = '1;
    stop_cyc = 0;
    while (tx_o === 1'b1 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (tx_o !== 1'b0) begin
      report_failure("no start bit seen on tx_o");
    end else begin
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      for (int k = 0; k < 10; k++) begin
        bits[k]  = tx_o;
        stop_cyc = cyc;
        if (k < 9) repeat (CLKS_PER_BIT) @(negedge clk);
      end
    end
  endtask

  // ready pulses are one cycle long and only inside a request
  assert property (@(posedge clk) disable iff (!rst) imem_ready_o |=> !imem_ready_o)
    else report_failure("imem_ready_o stayed high for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst) dmem_ready_o |=> !dmem_ready_o)
    else report_failure("dmem_ready_o stayed high for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst) imem_ready_o |-> imem_valid_i)
    else report_failure("imem_ready_o came while imem_valid_i was low");
  assert property (@(posedge clk) disable iff (!rst) dmem_ready_o |-> dmem_valid_i)
    else report_failure("dmem_ready_o came while dmem_valid_i was low");

  initial begin
    logic [31:0] d;
    logic [31:0] rd;
    logic [31:0] rd2;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [3:0]  s;
    logic [7:0]  byte_val;
    logic [9:0]  frame;
    int          lat;
    int          lat2;
    int          rc;
    int          rc2;
    int          w;
    int          n;
    int          ticks;
    int          delta;
    int          stop_cyc;
    void'($urandom(32'hd404));
    rst = 1'b0;
    {imem_valid_i, imem_instr_i, imem_addr_i, imem_wdata_i, imem_wstrb_i} = '0;
    {dmem_valid_i, dmem_instr_i, dmem_addr_i, dmem_wdata_i, dmem_wstrb_i} = '0;
    repeat (3) @(negedge clk);
    verify_idle(); // inside reset
    repeat (3) @(posedge clk);
    #1 rst = 1'b1;
    @(negedge clk);
    verify_idle();

    // ram fill, partial writes, read back on both ports
    for (int i = 0; i < 8; i++) begin
      d = $urandom;
      bus_xfer(1'b1, BRAM_BASE + 4 * i, d, 4'hf, rd, lat, rc);
      compare("dmem write latency", 32'd1, lat);
      ram_model[i] = d;
    end
    for (int i = 0; i < 8; i++) begin
      w = $urandom_range(7);
      s = 4'($urandom_range(15, 1));
      d = $urandom;
      bus_xfer(1'b1, BRAM_BASE + 4 * w, d, s, rd, lat, rc);
      compare("dmem write latency", 32'd1, lat);
      ram_model[w] = merge_bytes(ram_model[w], d, s);
    end
    for (int i = 0; i < 8; i++) begin
      bus_xfer(1'b1, BRAM_BASE + 4 * i, 32'h0, 4'h0, rd, lat, rc);
      compare("dmem_rdata_o", ram_model[i], rd);
      compare("dmem read latency", 32'd1, lat);
      bus_xfer(1'b0, BRAM_BASE + 4 * i, 32'h0, 4'h0, rd, lat, rc);
      compare("imem_rdata_o", ram_model[i], rd);
      compare("imem read latency", 32'd1, lat);
    end

    // same-cycle requests, data port first
    fork
      bus_xfer(1'b1, BRAM_BASE + 32'hc, 32'h0, 4'h0, rd, lat, rc);
      bus_xfer(1'b0, BRAM_BASE + 32'hc, 32'h0, 4'h0, rd2, lat2, rc2);
    join
    compare("dmem_rdata_o", ram_model[3], rd);
    compare("imem_rdata_o", ram_model[3], rd2);
    assert (rc < rc2) else report_failure("dmem read did not win over imem read");
    d = $urandom;
    fork
      bus_xfer(1'b1, BRAM_BASE + 32'h8, d, 4'hf, rd, lat, rc);
      bus_xfer(1'b0, BRAM_BASE + 32'h14, 32'h0, 4'h0, rd2, lat2, rc2);
    join
    ram_model[2] = d;
    compare("imem_rdata_o", ram_model[5], rd2);
    assert (rc < rc2) else report_failure("dmem write did not win over imem read");
    bus_xfer(1'b0, BRAM_BASE + 32'h8, 32'h0, 4'h0, rd, lat, rc);
    compare("imem_rdata_o", ram_model[2], rd);

    // mtime rate, mtimecmp and msip
    bus_xfer(1'b1, CLINT_BASE + CLINT_MTIME_LO, 32'h0, 4'h0, t0, lat, rc);
    repeat (40) @(posedge clk);
    bus_xfer(1'b1, CLINT_BASE + CLINT_MTIME_LO, 32'h0, 4'h0, t1, lat, rc2);
    ticks = (rc2 - rc) / RTC_DIV;
    delta = int'(t1 - t0);
    assert (delta >= ticks - 1 && delta <= ticks + 1)
      else report_failure($sformatf("mtime moved %0d ticks in %0d cycles", delta, rc2 - rc));
    bus_xfer(1'b1, CLINT_BASE + CLINT_MTIMECMP_LO, t1 + 32'd5, 4'hf, rd, lat, rc);
    bus_xfer(1'b1, CLINT_BASE + CLINT_MTIMECMP_HI, 32'h0, 4'hf, rd, lat, rc);
    compare("mtip_o", 32'h0, 32'(mtip_o));
    n = 0;
    while (!mtip_o && n < 6 * RTC_DIV + 2) begin
      @(negedge clk);
      n++;
    end
    assert (mtip_o) else report_failure("mtip_o did not rise once mtime reached mtimecmp");
    bus_xfer(1'b1, CLINT_BASE + CLINT_MSIP, 32'h1, 4'h1, rd, lat, rc);
    compare("msip_o", 32'h1, 32'(msip_o));
    bus_xfer(1'b1, CLINT_BASE + CLINT_MSIP, 32'h0, 4'h1, rd, lat, rc);
    compare("msip_o", 32'h0, 32'(msip_o));

    // uart frame, busy status and held second write
    byte_val = 8'($urandom);
    fork
      decode_frame(frame, stop_cyc);
      begin
        bus_xfer(1'b1, UART_BASE + UART_DATA, {24'h0, byte_val}, 4'h1, rd, lat, rc);
        bus_xfer(1'b1, UART_BASE + UART_STATUS, 32'h0, 4'h0, rd, lat, rc);
        compare("dmem_rdata_o", 32'h1, rd); // busy
        bus_xfer(1'b1, UART_BASE + UART_DATA, {24'h0, ~byte_val}, 4'h1, rd, lat, rc);
      end
    join
    compare("tx_o", {22'h0, 1'b1, byte_val, 1'b0}, {22'h0, frame});
    assert (rc > stop_cyc) else report_failure("second uart write finished before the stop bit");

    // unmapped fetch next to a ram read
    fork
      bus_xfer(1'b0, 32'h8000_0000, 32'h0, 4'h0, rd2, lat2, rc2);
      bus_xfer(1'b1, BRAM_BASE + 32'h4, 32'h0, 4'h0, rd, lat, rc);
    join
    compare("imem_rdata_o", 32'h0, rd2);
    compare("imem read latency", 32'd1, lat2);
    compare("dmem_rdata_o", ram_model[1], rd);
    compare("dmem read latency", 32'd1, lat);

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* src/soc_bus.sv */
module soc_bus #(
  parameter int BRAM_WORDS   = 256,
  parameter int RTC_DIV      = 4,
  parameter int CLKS_PER_BIT = 8
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             imem_valid_i,
  input  logic                             imem_instr_i,
  input  logic [soc_bus_pkg::ADDR_W-1:0]   imem_addr_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]   imem_wdata_i,
  input  logic [soc_bus_pkg::STRB_W-1:0]   imem_wstrb_i,
  output logic [soc_bus_pkg::DATA_W-1:0]   imem_rdata_o,
  output logic                             imem_ready_o,
  input  logic                             dmem_valid_i,
  input  logic                             dmem_instr_i,
  input  logic [soc_bus_pkg::ADDR_W-1:0]   dmem_addr_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]   dmem_wdata_i,
  input  logic [soc_bus_pkg::STRB_W-1:0]   dmem_wstrb_i,
  output logic [soc_bus_pkg::DATA_W-1:0]   dmem_rdata_o,
  output logic                             dmem_ready_o,
  output logic                             tx_o,
  output logic                             msip_o,
  output logic                             mtip_o
);

  mem_if imem_bus ();
  mem_if dmem_bus ();
  mem_if bram_bus ();
  mem_if clint_bus ();
  mem_if uart_bus ();

  // master ports from pins
  assign imem_bus.valid = imem_valid_i;
  assign imem_bus.instr = imem_instr_i;
  assign imem_bus.addr  = imem_addr_i;
  assign imem_bus.wdata = imem_wdata_i;
  assign imem_bus.wstrb = imem_wstrb_i;
  assign imem_rdata_o   = imem_bus.rdata;
  assign imem_ready_o   = imem_bus.ready;

  assign dmem_bus.valid = dmem_valid_i;
  assign dmem_bus.instr = dmem_instr_i;
  assign dmem_bus.addr  = dmem_addr_i;
  assign dmem_bus.wdata = dmem_wdata_i;
  assign dmem_bus.wstrb = dmem_wstrb_i;
  assign dmem_rdata_o   = dmem_bus.rdata;
  assign dmem_ready_o   = dmem_bus.ready;

  bus_xbar i_bus_xbar (
    .clk       (clk),
    .rst       (rst),
    .imem      (imem_bus),
    .dmem      (dmem_bus),
    .bram_bus  (bram_bus),
    .clint_bus (clint_bus),
    .uart_bus  (uart_bus)
  );

  bram #(.BRAM_WORDS(BRAM_WORDS)) i_bram (
    .clk (clk),
    .rst (rst),
    .bus (bram_bus)
  );

  clint #(.RTC_DIV(RTC_DIV)) i_clint (
    .clk    (clk),
    .rst    (rst),
    .bus    (clint_bus),
    .msip_o (msip_o),
    .mtip_o (mtip_o)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
    .clk  (clk),
    .rst  (rst),
    .bus  (uart_bus),
    .tx_o (tx_o)
  );

endmodule

/* src/uart_tx.sv */
module uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic clk,
  input  logic rst,
  mem_if.slave bus,
  output logic tx_o
);
  import soc_bus_pkg::*;

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  logic [9:0]        shift_q; // stop, data, start
  logic [3:0]        bits_q;  // bits left in the frame
  logic [CNT_W-1:0]  cnt_q;
  logic              busy;
  logic              bit_end;
  logic              data_wr;
  logic              accept;
  logic              load;
  logic              ready_q;
  logic [DATA_W-1:0] rdata_q;

  assign busy    = bits_q != 4'd0;
  assign bit_end = cnt_q == CNT_W'(CLKS_PER_BIT - 1);
  assign data_wr = (bus.addr == UART_DATA) && bus.wstrb[0];

  // a data write waits here while a frame is on the line
  assign accept = bus.valid && !ready_q && !(data_wr && busy);
  // shifter loads in the ready cycle, request fields still held
  assign load   = bus.valid && ready_q && data_wr;

  always_ff @(posedge clk) begin
    if (!rst) begin
      shift_q <= '1; // line idles high
      bits_q  <= 4'd0;
      cnt_q   <= '0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
      if (load) begin
        shift_q <= {1'b1, bus.wdata[7:0], 1'b0};
        bits_q  <= 4'd10;
        cnt_q   <= '0;
      end else if (busy) begin
        if (bit_end) begin
          shift_q <= {1'b1, shift_q[9:1]}; // lsb first
          bits_q  <= bits_q - 4'd1;
          cnt_q   <= '0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_q <= (bus.addr == UART_STATUS) ? {{(DATA_W-1){1'b0}}, busy} : '0;
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;
  assign tx_o      = shift_q[0];

endmodule

/* src/clint.sv */
module clint #(
  parameter int RTC_DIV = 4
) (
  input  logic clk,
  input  logic rst,
  mem_if.slave bus,
  output logic msip_o,
  output logic mtip_o
);
  import soc_bus_pkg::*;

  localparam int DIV_W = (RTC_DIV > 1) ? $clog2(RTC_DIV) : 1;

  logic [DIV_W-1:0]  div_q;
  logic              tick;
  logic [63:0]       mtime_q;
  logic [63:0]       mtime_d;
  logic [63:0]       mtimecmp_q;
  logic [63:0]       mtimecmp_d;
  logic              msip_q;
  logic              msip_d;
  logic              mtip_q;
  logic              access;
  logic              wr;
  logic              ready_q;
  logic [DATA_W-1:0] rd_word;
  logic [DATA_W-1:0] rdata_q;

  assign tick   = div_q == DIV_W'(RTC_DIV - 1); // real-time tick
  assign access = bus.valid && !ready_q;
  assign wr     = access && (bus.wstrb != '0);

  // register writes, a bus write to mtime overrides the tick
  always_comb begin
    mtime_d    = tick ? mtime_q + 64'd1 : mtime_q;
    mtimecmp_d = mtimecmp_q;
    msip_d     = msip_q;
    if (wr) begin
      case (bus.addr)
        CLINT_MSIP: begin
          if (bus.wstrb[0]) msip_d = bus.wdata[0];
        end
        CLINT_MTIMECMP_LO:
          mtimecmp_d[31:0] = strb_merge(mtimecmp_q[31:0], bus.wdata, bus.wstrb);
        CLINT_MTIMECMP_HI:
          mtimecmp_d[63:32] = strb_merge(mtimecmp_q[63:32], bus.wdata, bus.wstrb);
        CLINT_MTIME_LO:
          mtime_d[31:0] = strb_merge(mtime_q[31:0], bus.wdata, bus.wstrb);
        CLINT_MTIME_HI:
          mtime_d[63:32] = strb_merge(mtime_q[63:32], bus.wdata, bus.wstrb);
        default: ; // unknown offset, write dropped
      endcase
    end
  end

  // read mux
  always_comb begin
    case (bus.addr)
      CLINT_MSIP:        rd_word = {{(DATA_W-1){1'b0}}, msip_q};
      CLINT_MTIMECMP_LO: rd_word = mtimecmp_q[31:0];
      CLINT_MTIMECMP_HI: rd_word = mtimecmp_q[63:32];
      CLINT_MTIME_LO:    rd_word = mtime_q[31:0];
      CLINT_MTIME_HI:    rd_word = mtime_q[63:32];
      default:           rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      div_q      <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1; // no timer interrupt out of reset
      msip_q     <= 1'b0;
      mtip_q     <= 1'b0;
      ready_q    <= 1'b0;
    end else begin
      div_q      <= tick ? '0 : div_q + 1'b1;
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      msip_q     <= msip_d;
      mtip_q     <= mtime_q >= mtimecmp_q;
      ready_q    <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) rdata_q <= rd_word;
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;
  assign msip_o    = msip_q;
  assign mtip_o    = mtip_q;

endmodule

/* src/bram.sv */
module bram #(
  parameter int BRAM_WORDS = 256
) (
  input logic  clk,
  input logic  rst,
  mem_if.slave bus
);
  import soc_bus_pkg::*;

  localparam int IDX_W = (BRAM_WORDS > 1) ? $clog2(BRAM_WORDS) : 1;

  logic [DATA_W-1:0] mem [BRAM_WORDS];
  logic [IDX_W-1:0]  idx;
  logic              access;
  logic              ready_q;
  logic [DATA_W-1:0] rdata_q;

  assign idx    = bus.addr[IDX_W+1:2]; // byte address to word index
  assign access = bus.valid && !ready_q;

  // storage and read data
  always_ff @(posedge clk) begin
    if (access) begin
      if (bus.wstrb != '0) begin
        mem[idx] <= strb_merge(mem[idx], bus.wdata, bus.wstrb);
      end
      rdata_q <= mem[idx]; // old word on a write
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

endmodule

/* src/bus_xbar.sv */
module bus_xbar (
  input logic   clk,
  input logic   rst,
  mem_if.slave  imem,
  mem_if.slave  dmem,
  mem_if.master bram_bus,
  mem_if.master clint_bus,
  mem_if.master uart_bus
);
  import soc_bus_pkg::*;

  localparam int NSLV = 3;

  // indexed by slave_e
  localparam logic [ADDR_W-1:0] SLV_BASE [NSLV] = '{BRAM_BASE, CLINT_BASE, UART_BASE};
  localparam logic [ADDR_W-1:0] SLV_SPAN [NSLV] = '{BRAM_SPAN, CLINT_SPAN, UART_SPAN};

  typedef enum logic [1:0] {OWN_FREE, OWN_IMEM, OWN_DMEM} owner_e;

  owner_e            owner_q [NSLV];
  owner_e            owner_d [NSLV];
  owner_e            route   [NSLV]; // master feeding each slave this cycle
  logic [NSLV-1:0]   i_hit;
  logic [NSLV-1:0]   d_hit;
  logic              i_unmapped;
  logic              d_unmapped;
  logic              i_unm_q;        // default responder, one per master
  logic              d_unm_q;
  logic              s_valid [NSLV];
  logic              s_instr [NSLV];
  logic [ADDR_W-1:0] s_addr  [NSLV];
  logic [DATA_W-1:0] s_wdata [NSLV];
  logic [STRB_W-1:0] s_wstrb [NSLV];
  logic [NSLV-1:0]   s_ready;
  logic [DATA_W-1:0] s_rdata [NSLV];

  // address decode, range check by offset so wraparound drops out
  always_comb begin
    for (int s = 0; s < NSLV; s++) begin
      i_hit[s] = imem.valid && ((imem.addr - SLV_BASE[s]) < SLV_SPAN[s]);
      d_hit[s] = dmem.valid && ((dmem.addr - SLV_BASE[s]) < SLV_SPAN[s]);
    end
    i_unmapped = imem.valid && (i_hit == '0);
    d_unmapped = dmem.valid && (d_hit == '0);
  end

  // grant and request mux
  always_comb begin
    for (int s = 0; s < NSLV; s++) begin
      if (owner_q[s] != OWN_FREE) begin
        route[s] = owner_q[s];   // held until the slave answers
      end else if (d_hit[s]) begin
        route[s] = OWN_DMEM;     // data port wins a tie
      end else if (i_hit[s]) begin
        route[s] = OWN_IMEM;
      end else begin
        route[s] = OWN_FREE;
      end
      owner_d[s] = s_ready[s] ? OWN_FREE : route[s];

      case (route[s])
        OWN_DMEM: begin
          s_valid[s] = dmem.valid;
          s_instr[s] = dmem.instr;
          s_addr[s]  = dmem.addr - SLV_BASE[s];
          s_wdata[s] = dmem.wdata;
          s_wstrb[s] = dmem.wstrb;
        end
        OWN_IMEM: begin
          s_valid[s] = imem.valid;
          s_instr[s] = imem.instr;
          s_addr[s]  = imem.addr - SLV_BASE[s];
          s_wdata[s] = imem.wdata;
          s_wstrb[s] = imem.wstrb;
        end
        default: begin
          s_valid[s] = 1'b0;
          s_instr[s] = 1'b0;
          s_addr[s]  = '0;
          s_wdata[s] = '0;
          s_wstrb[s] = '0;
        end
      endcase
    end
  end

  assign bram_bus.valid  = s_valid[SLV_BRAM];
  assign bram_bus.instr  = s_instr[SLV_BRAM];
  assign bram_bus.addr   = s_addr[SLV_BRAM];
  assign bram_bus.wdata  = s_wdata[SLV_BRAM];
  assign bram_bus.wstrb  = s_wstrb[SLV_BRAM];
  assign clint_bus.valid = s_valid[SLV_CLINT];
  assign clint_bus.instr = s_instr[SLV_CLINT];
  assign clint_bus.addr  = s_addr[SLV_CLINT];
  assign clint_bus.wdata = s_wdata[SLV_CLINT];
  assign clint_bus.wstrb = s_wstrb[SLV_CLINT];
  assign uart_bus.valid  = s_valid[SLV_UART];
  assign uart_bus.instr  = s_instr[SLV_UART];
  assign uart_bus.addr   = s_addr[SLV_UART];
  assign uart_bus.wdata  = s_wdata[SLV_UART];
  assign uart_bus.wstrb  = s_wstrb[SLV_UART];

  assign s_ready[SLV_BRAM]  = bram_bus.ready;
  assign s_ready[SLV_CLINT] = clint_bus.ready;
  assign s_ready[SLV_UART]  = uart_bus.ready;
  assign s_rdata[SLV_BRAM]  = bram_bus.rdata;
  assign s_rdata[SLV_CLINT] = clint_bus.rdata;
  assign s_rdata[SLV_UART]  = uart_bus.rdata;

  // response routing by owner
  always_comb begin
    imem.ready = i_unm_q;
    imem.rdata = '0;
    dmem.ready = d_unm_q;
    dmem.rdata = '0;
    for (int s = 0; s < NSLV; s++) begin
      if (s_ready[s] && owner_q[s] == OWN_IMEM) begin
        imem.ready = 1'b1;
        imem.rdata = s_rdata[s];
      end
      if (s_ready[s] && owner_q[s] == OWN_DMEM) begin
        dmem.ready = 1'b1;
        dmem.rdata = s_rdata[s];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      owner_q <= '{default: OWN_FREE};
      i_unm_q <= 1'b0;
      d_unm_q <= 1'b0;
    end else begin
      owner_q <= owner_d;
      i_unm_q <= i_unmapped && !i_unm_q; // never two cycles in a row
      d_unm_q <= d_unmapped && !d_unm_q;
    end
  end

endmodule

/* src/mem_if.sv */
interface mem_if;
  import soc_bus_pkg::*;

  logic              valid;
  logic              instr; // fetch vs data access
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb; // zero means read
  logic [DATA_W-1:0] rdata;
  logic              ready; // one-cycle pulse

  modport master (
    output valid, instr, addr, wdata, wstrb,
    input  rdata, ready
  );

  modport slave (
    input  valid, instr, addr, wdata, wstrb,
    output rdata, ready
  );

endinterface

/* src/soc_bus_pkg.sv */
package soc_bus_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // address map
  localparam logic [ADDR_W-1:0] BRAM_BASE  = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] BRAM_SPAN  = 32'h0000_1000; // 1024 words max
  localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [ADDR_W-1:0] CLINT_SPAN = 32'h0001_0000;
  localparam logic [ADDR_W-1:0] UART_BASE  = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] UART_SPAN  = 32'h0000_0100;

  // clint register offsets
  localparam logic [ADDR_W-1:0] CLINT_MSIP        = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] CLINT_MTIMECMP_LO = 32'h0000_4000;
  localparam logic [ADDR_W-1:0] CLINT_MTIMECMP_HI = 32'h0000_4004;
  localparam logic [ADDR_W-1:0] CLINT_MTIME_LO    = 32'h0000_bff8;
  localparam logic [ADDR_W-1:0] CLINT_MTIME_HI    = 32'h0000_bffc;

  // uart register offsets, status bit 0 is busy
  localparam logic [ADDR_W-1:0] UART_DATA   = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] UART_STATUS = 32'h0000_0004;

  typedef enum logic [1:0] {SLV_BRAM, SLV_CLINT, SLV_UART} slave_e;

  // byte-lane merge of a write into an existing word
  function automatic logic [DATA_W-1:0] strb_merge(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] merged;
    merged = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

endpackage
